// File: Bender.yml
package:
  name: mips_cpu

sources:
  - logic/mips_pkg.sv
  - logic/mips_regfile.sv
  - logic/mips_alu.sv
  - logic/mips_load_align.sv
  - logic/mips_store_merge.sv
  - logic/mips_cpu_harvard.sv
  - target: test
    files:
      - test/mips_cpu_tb.sv

// File: logic/mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
    input  mips_pkg::word_t operand_a,
    input  mips_pkg::word_t operand_b,
    input  mips_pkg::word_t instr_word,
    output mips_pkg::word_t result,
    output mips_pkg::word_t product_hi,
    output mips_pkg::word_t product_lo,
    output mips_pkg::word_t effective_addr,
    output logic            branch_taken
);
    mips_pkg::opcode_t  opcode;
    mips_pkg::funct_t   funct;
    logic [4:0]         shamt;
    mips_pkg::word_t    imm_sext;
    mips_pkg::word_t    imm_zext;
    logic signed [63:0] prod_signed;
    logic [63:0]        prod_unsigned;

    assign opcode   = instr_word[31:26];
    assign funct    = instr_word[5:0];
    assign shamt    = instr_word[10:6];
    assign imm_sext = {{16{instr_word[15]}}, instr_word[15:0]};
    assign imm_zext = {16'h0000, instr_word[15:0]};

    // both products, selected by funct below
    assign prod_signed   = $signed(operand_a) * $signed(operand_b);
    assign prod_unsigned = {32'h0, operand_a} * {32'h0, operand_b};

    assign product_hi = (funct == mips_pkg::fn_multu) ? prod_unsigned[63:32]
                                                      : prod_signed[63:32];
    assign product_lo = (funct == mips_pkg::fn_multu) ? prod_unsigned[31:0]
                                                      : prod_signed[31:0];

    // loads and stores use base plus signed offset
    assign effective_addr = operand_a + imm_sext;

    always_comb begin
        result = '0;
        case (opcode)
            mips_pkg::op_special: begin
                case (funct)
                    mips_pkg::fn_sll:  result = operand_b << shamt;
                    mips_pkg::fn_srl:  result = operand_b >> shamt;
                    mips_pkg::fn_sra:  result = $signed(operand_b) >>> shamt;
                    mips_pkg::fn_addu: result = operand_a + operand_b;
                    mips_pkg::fn_subu: result = operand_a - operand_b;
                    mips_pkg::fn_and:  result = operand_a & operand_b;
                    mips_pkg::fn_or:   result = operand_a | operand_b;
                    mips_pkg::fn_xor:  result = operand_a ^ operand_b;
                    mips_pkg::fn_nor:  result = ~(operand_a | operand_b);
                    mips_pkg::fn_slt: begin
                        result = {31'h0, $signed(operand_a) < $signed(operand_b)};
                    end
                    mips_pkg::fn_sltu: result = {31'h0, operand_a < operand_b};
                    default:           result = '0;
                endcase
            end
            mips_pkg::op_addiu: result = operand_a + imm_sext;
            mips_pkg::op_slti:  result = {31'h0, $signed(operand_a) < $signed(imm_sext)};
            // sltiu still sign-extends, then compares unsigned
            mips_pkg::op_sltiu: result = {31'h0, operand_a < imm_sext};
            mips_pkg::op_andi:  result = operand_a & imm_zext;
            mips_pkg::op_ori:   result = operand_a | imm_zext;
            mips_pkg::op_xori:  result = operand_a ^ imm_zext;
            mips_pkg::op_lui:   result = {instr_word[15:0], 16'h0000};
            default:            result = '0;
        endcase
    end

    // branch conditions
    always_comb begin
        case (opcode)
            mips_pkg::op_beq:  branch_taken = (operand_a == operand_b);
            mips_pkg::op_bne:  branch_taken = (operand_a != operand_b);
            mips_pkg::op_blez: branch_taken = operand_a[31] || (operand_a == '0);
            mips_pkg::op_bgtz: branch_taken = !operand_a[31] && (operand_a != '0);
            default:           branch_taken = 1'b0;
        endcase
    end

endmodule

// File: logic/mips_cpu_harvard.sv
`timescale 1ns/10ps

module mips_cpu_harvard (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output mips_pkg::word_t register_v0,
    input  logic            clk_enable,
    output mips_pkg::word_t instr_address,
    input  mips_pkg::word_t instr_readdata,
    output mips_pkg::word_t data_address,
    output logic            data_write,
    output logic            data_read,
    output mips_pkg::word_t data_writedata,
    input  mips_pkg::word_t data_readdata
);
    mips_pkg::cpu_state_t state;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      delay_slot;
    mips_pkg::word_t      next_target;
    mips_pkg::word_t      hi_reg;
    mips_pkg::word_t      lo_reg;
    logic                 cpu_active;
    logic                 in_exec;

    mips_pkg::opcode_t  opcode;
    mips_pkg::funct_t   funct;
    logic               is_rtype, is_mult, is_mfhi, is_mflo, is_jr, is_jalr;
    logic               is_j, is_jal, is_alu_imm, is_load, is_store, is_partial;
    logic               reg_write;
    mips_pkg::reg_idx_t write_index;
    mips_pkg::word_t    write_data;
    mips_pkg::word_t    reg_a, reg_b;
    mips_pkg::word_t    alu_result, prod_hi, prod_lo, eff_addr, load_value;
    logic               branch_taken;

    assign opcode = instr_readdata[31:26];
    assign funct  = instr_readdata[5:0];

    // instruction classes
    assign is_rtype   = (opcode == mips_pkg::op_special);
    assign is_mult    = is_rtype && (funct == mips_pkg::fn_mult || funct == mips_pkg::fn_multu);
    assign is_mfhi    = is_rtype && (funct == mips_pkg::fn_mfhi);
    assign is_mflo    = is_rtype && (funct == mips_pkg::fn_mflo);
    assign is_jr      = is_rtype && (funct == mips_pkg::fn_jr);
    assign is_jalr    = is_rtype && (funct == mips_pkg::fn_jalr);
    assign is_j       = (opcode == mips_pkg::op_j);
    assign is_jal     = (opcode == mips_pkg::op_jal);
    assign is_alu_imm = (opcode[5:3] == 3'b001);
    assign is_load    = (opcode[5:3] == 3'b100);
    assign is_partial = (opcode == mips_pkg::op_sb) || (opcode == mips_pkg::op_sh);
    assign is_store   = is_partial || (opcode == mips_pkg::op_sw);

    assign reg_write = (is_rtype && !is_mult && !is_jr) || is_alu_imm || is_load || is_jal;
    assign in_exec   = cpu_active && (state == mips_pkg::st_exec);

    // link targets rd for jalr, ra for jal
    assign write_index = is_jal ? mips_pkg::reg_ra
                       : (is_rtype ? instr_readdata[15:11] : instr_readdata[20:16]);

    always_comb begin
        if (is_jal || is_jalr) begin
            write_data = delay_slot + 32'd4;
        end else if (is_mfhi) begin
            write_data = hi_reg;
        end else if (is_mflo) begin
            write_data = lo_reg;
        end else if (is_load) begin
            write_data = load_value;
        end else begin
            write_data = alu_result;
        end
    end

    mips_regfile i_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .read_index_a (instr_readdata[25:21]),
        .read_index_b (instr_readdata[20:16]),
        .write_enable (in_exec && reg_write),
        .write_index  (write_index),
        .write_data   (write_data),
        .read_data_a  (reg_a),
        .read_data_b  (reg_b),
        .register_v0  (register_v0)
    );

    mips_alu i_alu (
        .operand_a      (reg_a),
        .operand_b      (reg_b),
        .instr_word     (instr_readdata),
        .result         (alu_result),
        .product_hi     (prod_hi),
        .product_lo     (prod_lo),
        .effective_addr (eff_addr),
        .branch_taken   (branch_taken)
    );

    mips_load_align i_load_align (
        .opcode         (opcode),
        .effective_addr (eff_addr),
        .mem_word       (data_readdata),
        .load_value     (load_value)
    );

    mips_store_merge i_store_merge (
        .opcode         (opcode),
        .effective_addr (eff_addr),
        .reg_word       (reg_b),
        .mem_word       (data_readdata),
        .write_word     (data_writedata)
    );

    // memory port control
    assign data_address = {eff_addr[31:2], 2'b00};
    assign data_write   = in_exec && is_store;
    // partial stores fetch the old word one cycle ahead
    assign data_read    = cpu_active && ((is_load && state == mips_pkg::st_exec)
                                      || (is_partial && state == mips_pkg::st_fetch));

    // target for the slot after the delay slot
    always_comb begin
        if (branch_taken) begin
            next_target = delay_slot + {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};
        end else if (is_j || is_jal) begin
            next_target = {delay_slot[31:28], instr_readdata[25:0], 2'b00};
        end else if (is_jr || is_jalr) begin
            next_target = reg_a;
        end else begin
            next_target = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= mips_pkg::st_fetch;
            pc         <= mips_pkg::reset_vector;
            delay_slot <= mips_pkg::reset_vector + 32'd4;
            cpu_active <= 1'b1;
        end else if (clk_enable && cpu_active) begin
            if (state == mips_pkg::st_fetch) begin
                state <= mips_pkg::st_exec;
            end else begin
                state      <= mips_pkg::st_fetch;
                pc         <= delay_slot;
                delay_slot <= next_target;
                // halt once the next fetch would be address 0
                if (delay_slot == '0) begin
                    cpu_active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_reg <= '0;
            lo_reg <= '0;
        end else if (clk_enable && in_exec && is_mult) begin
            hi_reg <= prod_hi;
            lo_reg <= prod_lo;
        end
    end

    assign instr_address = pc;
    assign active        = cpu_active;

endmodule

// File: logic/mips_load_align.sv
`timescale 1ns/10ps

module mips_load_align (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::word_t   effective_addr,
    input  mips_pkg::word_t   mem_word,
    output mips_pkg::word_t   load_value
);
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // big-endian, offset 0 is the top byte
    always_comb begin
        case (effective_addr[1:0])
            2'd0:    byte_lane = mem_word[31:24];
            2'd1:    byte_lane = mem_word[23:16];
            2'd2:    byte_lane = mem_word[15:8];
            default: byte_lane = mem_word[7:0];
        endcase
    end

    assign half_lane = effective_addr[1] ? mem_word[15:0] : mem_word[31:16];

    always_comb begin
        case (opcode)
            mips_pkg::op_lb:  load_value = {{24{byte_lane[7]}}, byte_lane};
            mips_pkg::op_lbu: load_value = {24'h0, byte_lane};
            mips_pkg::op_lh:  load_value = {{16{half_lane[15]}}, half_lane};
            mips_pkg::op_lhu: load_value = {16'h0, half_lane};
            mips_pkg::op_lw:  load_value = mem_word;
            default:          load_value = mem_word;
        endcase
    end

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_j       = 6'h02;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_blez    = 6'h06;
    localparam opcode_t op_bgtz    = 6'h07;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_lb      = 6'h20;
    localparam opcode_t op_lh      = 6'h21;
    localparam opcode_t op_lw      = 6'h23;
    localparam opcode_t op_lbu     = 6'h24;
    localparam opcode_t op_lhu     = 6'h25;
    localparam opcode_t op_sb      = 6'h28;
    localparam opcode_t op_sh      = 6'h29;
    localparam opcode_t op_sw      = 6'h2b;

    // funct field of special opcode
    localparam funct_t fn_sll   = 6'h00;
    localparam funct_t fn_srl   = 6'h02;
    localparam funct_t fn_sra   = 6'h03;
    localparam funct_t fn_jr    = 6'h08;
    localparam funct_t fn_jalr  = 6'h09;
    localparam funct_t fn_mfhi  = 6'h10;
    localparam funct_t fn_mflo  = 6'h12;
    localparam funct_t fn_mult  = 6'h18;
    localparam funct_t fn_multu = 6'h19;
    localparam funct_t fn_addu  = 6'h21;
    localparam funct_t fn_subu  = 6'h23;
    localparam funct_t fn_and   = 6'h24;
    localparam funct_t fn_or    = 6'h25;
    localparam funct_t fn_xor   = 6'h26;
    localparam funct_t fn_nor   = 6'h27;
    localparam funct_t fn_slt   = 6'h2a;
    localparam funct_t fn_sltu  = 6'h2b;

    localparam word_t reset_vector = 32'hbfc0_0000;

    localparam reg_idx_t reg_v0 = 5'd2;
    localparam reg_idx_t reg_ra = 5'd31;

    typedef enum logic {
        st_fetch,
        st_exec
    } cpu_state_t;

endpackage

// File: logic/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile (
    input  logic               clk,
    input  logic               reset,
    input  logic               clk_enable,
    input  mips_pkg::reg_idx_t read_index_a,
    input  mips_pkg::reg_idx_t read_index_b,
    input  logic               write_enable,
    input  mips_pkg::reg_idx_t write_index,
    input  mips_pkg::word_t    write_data,
    output mips_pkg::word_t    read_data_a,
    output mips_pkg::word_t    read_data_b,
    output mips_pkg::word_t    register_v0
);
    // register zero has no storage
    mips_pkg::word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    assign read_data_a = (read_index_a == 5'd0) ? '0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? '0 : regs[read_index_b];

    // v0 tap for the top-level port
    assign register_v0 = regs[mips_pkg::reg_v0];

endmodule

// File: logic/mips_store_merge.sv
`timescale 1ns/10ps

module mips_store_merge (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::word_t   effective_addr,
    input  mips_pkg::word_t   reg_word,
    input  mips_pkg::word_t   mem_word,
    output mips_pkg::word_t   write_word
);
    always_comb begin
        write_word = mem_word;
        case (opcode)
            mips_pkg::op_sw: write_word = reg_word;
            mips_pkg::op_sb: begin
                // replace one big-endian byte lane
                case (effective_addr[1:0])
                    2'd0:    write_word[31:24] = reg_word[7:0];
                    2'd1:    write_word[23:16] = reg_word[7:0];
                    2'd2:    write_word[15:8]  = reg_word[7:0];
                    default: write_word[7:0]   = reg_word[7:0];
                endcase
            end
            mips_pkg::op_sh: begin
                if (effective_addr[1]) begin
                    write_word[15:0] = reg_word[15:0];
                end else begin
                    write_word[31:16] = reg_word[15:0];
                end
            end
            default: write_word = mem_word;
        endcase
    end

endmodule

// File: mips_cpu.f
logic/mips_pkg.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_load_align.sv
logic/mips_store_merge.sv
logic/mips_cpu_harvard.sv
test/mips_cpu_tb.sv

// File: test/mips_cpu_golden.txt
# test <name> <max instructions> / prog <addr> <count> <words> / data <addr> <word>
# v0 <expected> / mem <addr> <expected> / toggle (random clock enable) / end
test arith 12
prog bfc00000 9 3c081234 35085678 2409ffff 00085102 010a5826
    0120602a 016c1021 00000008 00000000
v0 13171320
end
test loads 16
prog bfc00000 12 24081000 81090001 910a0003 850b0000 950c0002 8d0d0000
    012a1021 004b1021 004c1021 004d1026 00000008 00000000
data 00001000 80f17f02
v0 7f0e80e4
end
test stores 12
prog bfc00000 9 24081000 240900ab 340abeef a1090002 a50a0006 ad090008
    8d020004 00000008 00000000
data 00001000 11223344
data 00001004 55667788
v0 5566beef
mem 00001000 1122ab44
mem 00001004 5566beef
mem 00001008 000000ab
end
test branches 20
prog bfc00000 15 24080005 11000003 24020001 1d000002 24420002 24420100
    0ff0000a 24420004 03e21023 0bf0000d 19000010 03e00008 24420008
    00005809 004b1021
v0 7f80004d
end
test multiply 14
prog bfc00000 11 2408fffd 24090007 01090018 00005010 01090019 00005810
    00006012 014b1021 004c1021 00000008 00000000
v0 fffffff0
end
test stores_stall 12
prog bfc00000 9 24081000 240900ab 340abeef a1090002 a50a0006 ad090008
    8d020004 00000008 00000000
data 00001000 11223344
data 00001004 55667788
toggle
v0 5566beef
mem 00001000 1122ab44
mem 00001004 5566beef
mem 00001008 000000ab
end

// File: test/mips_cpu_tb.sv
`timescale 1ns/10ps

module mips_cpu_tb;

    logic            clk;
    logic            reset;
    logic            active;
    mips_pkg::word_t register_v0;
    logic            clk_enable;
    mips_pkg::word_t instr_address;
    mips_pkg::word_t instr_readdata;
    mips_pkg::word_t data_address;
    logic            data_write;
    logic            data_read;
    mips_pkg::word_t data_writedata;
    mips_pkg::word_t data_readdata;

    // memories keyed by byte address
    mips_pkg::word_t imem [mips_pkg::word_t];
    mips_pkg::word_t dmem [mips_pkg::word_t];
    int              mem_version;

    logic            wr_pend;
    mips_pkg::word_t wr_addr;
    mips_pkg::word_t wr_data;

    string           cur_name;
    int              cur_max;
    logic            cur_toggle;
    mips_pkg::word_t exp_v0;
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];
    mips_pkg::word_t rng_state;
    int              tests_run;

    mips_cpu_harvard i_dut (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // instruction reads are combinational
    // data reads follow data_read and hold the last word otherwise
    always @(instr_address, data_address, data_read, mem_version) begin
        instr_readdata = imem.exists(instr_address) ? imem[instr_address] : '0;
        if (data_read === 1'b1) begin
            data_readdata = dmem.exists(data_address) ? dmem[data_address] : '0;
        end
    end

    // write request is stable mid-cycle, committed at the rising edge
    always @(negedge clk) begin
        wr_pend = data_write;
        wr_addr = data_address;
        wr_data = data_writedata;
    end

    always @(posedge clk) begin
        if (wr_pend === 1'b1 && clk_enable && !reset) begin
            dmem[wr_addr] = wr_data;
            mem_version++;
        end
    end

    function automatic mips_pkg::word_t xorshift(input mips_pkg::word_t s);
        mips_pkg::word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input mips_pkg::word_t expected,
                              input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: v0 expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_mem(input string name, input mips_pkg::word_t addr,
                             input mips_pkg::word_t expected, input mips_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: mem[%h] expected %h, actual %h",
                     name, addr, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic run_test();
        int              cycles;
        int              limit;
        mips_pkg::word_t got;
        cycles = 0;
        limit  = 2 * cur_max + 32;
        mem_version++;
        reset      = 1'b1;
        clk_enable = 1'b1;
        repeat (16) begin
            @(posedge clk);
            #1;
        end
        reset = 1'b0;
        while (active) begin
            @(posedge clk);
            if (clk_enable) begin
                cycles++;
            end
            #1;
            if (cur_toggle) begin
                rng_state  = xorshift(rng_state);
                clk_enable = (rng_state[1:0] != 2'b00);
            end
            if (cycles > limit) begin
                $display("Timeout: %s did not halt within %0d cycles", cur_name, limit);
                $display("Test failures found");
                $fatal(1);
            end
        end
        clk_enable = 1'b1;
        check_word(cur_name, exp_v0, register_v0);
        foreach (exp_addr[k]) begin
            got = dmem.exists(exp_addr[k]) ? dmem[exp_addr[k]] : '0;
            check_mem(cur_name, exp_addr[k], exp_data[k], got);
        end
        tests_run++;
        $display("%s done in %0d cycles", cur_name, cycles);
    endtask

    initial begin
        int              fd;
        int              r;
        int              n;
        string           tok;
        string           line;
        mips_pkg::word_t addr;
        mips_pkg::word_t val;
        reset          = 1'b1;
        clk_enable     = 1'b1;
        instr_readdata = '0;
        data_readdata  = '0;
        mem_version    = 0;
        tests_run      = 0;
        rng_state      = 32'd76;
        cur_toggle     = 1'b0;
        fd = $fopen("test/mips_cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file test/mips_cpu_golden.txt");
            $display("Test failures found");
            $fatal(1);
        end
        r = $fscanf(fd, "%s", tok);
        while (r == 1) begin
            if (tok[0] == "#") begin
                r = $fgets(line, fd);
            end else if (tok == "test") begin
                r = $fscanf(fd, "%s %d", cur_name, cur_max);
                imem.delete();
                dmem.delete();
                exp_addr.delete();
                exp_data.delete();
                cur_toggle = 1'b0;
            end else if (tok == "prog") begin
                r = $fscanf(fd, "%h %d", addr, n);
                for (int k = 0; k < n; k++) begin
                    r = $fscanf(fd, "%h", val);
                    imem[addr + 4 * k] = val;
                end
            end else if (tok == "data") begin
                r = $fscanf(fd, "%h %h", addr, val);
                dmem[addr] = val;
            end else if (tok == "v0") begin
                r = $fscanf(fd, "%h", exp_v0);
            end else if (tok == "mem") begin
                r = $fscanf(fd, "%h %h", addr, val);
                exp_addr.push_back(addr);
                exp_data.push_back(val);
            end else if (tok == "toggle") begin
                cur_toggle = 1'b1;
            end else if (tok == "end") begin
                run_test();
            end else begin
                $display("Unknown record %s in the golden file", tok);
                $display("Test failures found");
                $fatal(1);
            end
            r = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        if (tests_run > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("The golden file holds no complete test section");
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule
